// ==== video_pkg.sv ====
package video_pkg;

    localparam int pix_w = 8; // bits per colour channel

    // morphology operation applied to the binary window
    typedef enum logic [1:0] {
        MODE_PASS   = 2'd0,
        MODE_ERODE  = 2'd1,
        MODE_DILATE = 2'd2  // code 3 falls back to pass
    } mode_t;

    // output levels of a binary pixel, same on r, g and b
    localparam logic [pix_w-1:0] bin_white = 8'hFF;
    localparam logic [pix_w-1:0] bin_black = 8'h00;

endpackage : video_pkg

// ==== csr_pkg.sv ====
package csr_pkg;

    localparam int wb_adr_w    = 4;  // word address
    localparam int wb_dat_w    = 32;
    localparam int thresh_w    = 8;
    localparam int frame_cnt_w = 16;

    // register map, word addresses
    localparam logic [wb_adr_w-1:0] adr_ctrl   = 4'd0; // mode in [1:0], rw
    localparam logic [wb_adr_w-1:0] adr_thresh = 4'd1; // threshold in [7:0], rw
    localparam logic [wb_adr_w-1:0] adr_frames = 4'd2; // frame count in [15:0], ro

endpackage : csr_pkg

// ==== bin_csr.sv ====
module bin_csr
    import video_pkg::*, csr_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  logic [wb_adr_w-1:0] i_wb_adr,
    input  logic [wb_dat_w-1:0] i_wb_dat,
    input  logic [3:0]          i_wb_sel,
    input  logic                i_vsync,
    output logic [wb_dat_w-1:0] o_wb_dat,
    output logic                o_wb_ack,
    output mode_t               o_mode,
    output logic [thresh_w-1:0] o_thresh
);

    logic                      ack_set;
    logic                      wait_drop; // acked, waiting for stb low
    logic [$bits(mode_t)-1:0]  ctrl_q;
    logic [thresh_w-1:0]       thresh_q;
    logic [frame_cnt_w-1:0]    frame_cnt;
    logic                      vsync_q;
    logic [wb_dat_w-1:0]       rd_data;

    assign ack_set = i_wb_cyc & i_wb_stb & ~o_wb_ack & ~wait_drop;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_wb_ack  <= 1'b0;
            wait_drop <= 1'b0;
        end else begin
            o_wb_ack  <= ack_set;
            wait_drop <= i_wb_stb & (wait_drop | o_wb_ack);
        end
    end

    // written values land as the ack goes high
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctrl_q   <= '0;
            thresh_q <= '0;
        end else if (ack_set && i_wb_we && i_wb_sel[0]) begin
            case (i_wb_adr)
                adr_ctrl:   ctrl_q   <= i_wb_dat[$bits(mode_t)-1:0];
                adr_thresh: thresh_q <= i_wb_dat[thresh_w-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_data = '0; // unmapped reads as zero
        case (i_wb_adr)
            adr_ctrl:   rd_data = wb_dat_w'(ctrl_q);
            adr_thresh: rd_data = wb_dat_w'(thresh_q);
            adr_frames: rd_data = wb_dat_w'(frame_cnt);
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ack_set) begin
            o_wb_dat <= rd_data; // held through the ack cycle
        end
    end

    // active settings only move at frame boundaries
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_mode    <= MODE_PASS;
            o_thresh  <= '0;
            vsync_q   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            vsync_q <= i_vsync;
            if (i_vsync) begin
                o_mode   <= mode_t'(ctrl_q);
                o_thresh <= thresh_q;
            end
            if (i_vsync && !vsync_q) begin
                frame_cnt <= frame_cnt + 1'b1; // one per vsync pulse
            end
        end
    end

endmodule : bin_csr

// ==== bin_line_buffers.sv ====
module bin_line_buffers
    import video_pkg::*;
#(
    parameter  int H_ACT  = 1280,
    parameter  int V_ACT  = 720,
    parameter  int COLUMN = 3,
    localparam int XW     = $clog2(H_ACT),
    localparam int YW     = $clog2(V_ACT),
    localparam int PW     = $clog2(COLUMN)
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_hsync,
    input  logic              i_vsync,
    input  logic              i_de,
    input  logic [pix_w-1:0]  i_r,
    input  logic [pix_w-1:0]  i_g,
    input  logic [pix_w-1:0]  i_b,
    input  logic [XW-1:0]     i_x,
    input  logic [YW-1:0]     i_y,
    input  logic [pix_w-1:0]  i_thresh,
    output logic [COLUMN-1:0] o_window,
    output logic              o_hsync,
    output logic              o_vsync,
    output logic              o_de,
    output logic [XW-1:0]     o_x,
    output logic [YW-1:0]     o_y
);

    logic              bin;
    logic [PW-1:0]     ptr;     // buffer taking the current row
    logic [PW-1:0]     ptr_q;   // ptr of the pixel now in the window
    logic              cur_bit;
    logic [COLUMN-1:0] rd_bits;

    // zero threshold is the plain non-black test
    assign bin = (i_r > i_thresh) | (i_g > i_thresh) | (i_b > i_thresh);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptr <= '0;
        end else if (i_vsync) begin
            ptr <= '0;
        end else if (i_hsync && !o_hsync) begin // o_hsync is last cycle's hsync
            if (ptr == PW'(COLUMN - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < COLUMN; i++) begin : g_line
        logic line_mem [H_ACT];
        logic rd_q;

        always_ff @(posedge clk) begin
            if (i_de && ptr == PW'(i)) begin
                line_mem[i_x] <= bin;
            end
            rd_q <= line_mem[i_x]; // read-first, unused when writing
        end

        assign rd_bits[i] = rd_q;
    end

    // oldest row sits in the buffer right after the one being written
    always_comb begin
        int idx;
        for (int k = 0; k < COLUMN - 1; k++) begin
            idx = int'(ptr_q) + 1 + k;
            if (idx >= COLUMN) begin
                idx = idx - COLUMN;
            end
            o_window[k] = rd_bits[idx];
        end
        o_window[COLUMN-1] = cur_bit;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
            ptr_q   <= '0;
        end else begin
            o_hsync <= i_hsync;
            o_vsync <= i_vsync;
            o_de    <= i_de;
            ptr_q   <= ptr;
        end
    end

    always_ff @(posedge clk) begin
        cur_bit <= bin;
        o_x     <= i_x;
        o_y     <= i_y;
    end

endmodule : bin_line_buffers

// ==== bin_morph.sv ====
module bin_morph
    import video_pkg::*;
#(
    parameter  int H_ACT  = 1280,
    parameter  int V_ACT  = 720,
    parameter  int COLUMN = 3,
    localparam int XW     = $clog2(H_ACT),
    localparam int YW     = $clog2(V_ACT)
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic [COLUMN-1:0] i_window,
    input  logic              i_hsync,
    input  logic              i_vsync,
    input  logic              i_de,
    input  logic [XW-1:0]     i_x,
    input  logic [YW-1:0]     i_y,
    input  mode_t             i_mode,
    output logic [pix_w-1:0]  o_r,
    output logic [pix_w-1:0]  o_g,
    output logic [pix_w-1:0]  o_b,
    output logic              o_hsync,
    output logic              o_vsync,
    output logic              o_de,
    output logic [XW-1:0]     o_x,
    output logic [YW-1:0]     o_y
);

    logic [COLUMN-1:0] col_q [COLUMN-1]; // earlier columns, [0] newest
    logic              and_all;
    logic              or_all;
    logic              result;
    logic              blank;
    logic [YW-1:0]     adj_y;

    // cleared per line so columns left of x=0 read as 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < COLUMN - 1; k++) begin
                col_q[k] <= '0;
            end
        end else if (i_hsync || i_vsync) begin
            for (int k = 0; k < COLUMN - 1; k++) begin
                col_q[k] <= '0;
            end
        end else if (i_de) begin
            col_q[0] <= i_window;
            for (int k = 1; k < COLUMN - 1; k++) begin
                col_q[k] <= col_q[k-1];
            end
        end
    end

    always_comb begin
        and_all = &i_window;
        or_all  = |i_window;
        for (int k = 0; k < COLUMN - 1; k++) begin
            and_all = and_all & (&col_q[k]);
            or_all  = or_all | (|col_q[k]);
        end
        case (i_mode)
            MODE_ERODE:  result = and_all;
            MODE_DILATE: result = or_all;
            default:     result = i_window[0]; // oldest row, newest column
        endcase
    end

    assign blank = i_y < YW'(COLUMN - 1); // window not yet filled
    assign adj_y = blank ? '0 : i_y - YW'(COLUMN - 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
        end else begin
            o_hsync <= i_hsync;
            o_vsync <= i_vsync;
            o_de    <= i_de;
        end
    end

    always_ff @(posedge clk) begin
        o_x <= i_x;
        o_y <= adj_y;
        if (i_de && !blank && result) begin
            o_r <= bin_white;
            o_g <= bin_white;
            o_b <= bin_white;
        end else begin
            o_r <= bin_black;
            o_g <= bin_black;
            o_b <= bin_black;
        end
    end

endmodule : bin_morph

// ==== bin_filter_top.sv ====
module bin_filter_top
    import video_pkg::*, csr_pkg::*;
#(
    parameter  int H_ACT  = 1280,
    parameter  int V_ACT  = 720,
    parameter  int COLUMN = 3, // odd, 3 to 5
    localparam int XW     = $clog2(H_ACT),
    localparam int YW     = $clog2(V_ACT)
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  logic [wb_adr_w-1:0] i_wb_adr,
    input  logic [wb_dat_w-1:0] i_wb_dat,
    input  logic [3:0]          i_wb_sel,
    input  logic                i_hsync,
    input  logic                i_vsync,
    input  logic                i_de,
    input  logic [pix_w-1:0]    i_r,
    input  logic [pix_w-1:0]    i_g,
    input  logic [pix_w-1:0]    i_b,
    input  logic [XW-1:0]       i_x,
    input  logic [YW-1:0]       i_y,
    output logic [wb_dat_w-1:0] o_wb_dat,
    output logic                o_wb_ack,
    output logic [pix_w-1:0]    o_r,
    output logic [pix_w-1:0]    o_g,
    output logic [pix_w-1:0]    o_b,
    output logic                o_hsync,
    output logic                o_vsync,
    output logic                o_de,
    output logic [XW-1:0]       o_x,
    output logic [YW-1:0]       o_y
);

    mode_t               mode;
    logic [thresh_w-1:0] thresh;
    logic [COLUMN-1:0]   window;
    logic                lb_hsync;
    logic                lb_vsync;
    logic                lb_de;
    logic [XW-1:0]       lb_x;
    logic [YW-1:0]       lb_y;

    bin_csr u_csr (
        .clk      (clk),
        .rstn     (rstn),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .i_wb_sel (i_wb_sel),
        .i_vsync  (i_vsync), // frame boundary for the shadows
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .o_mode   (mode),
        .o_thresh (thresh)
    );

    bin_line_buffers #(
        .H_ACT  (H_ACT),
        .V_ACT  (V_ACT),
        .COLUMN (COLUMN)
    ) u_line_buffers (
        .clk      (clk),
        .rstn     (rstn),
        .i_hsync  (i_hsync),
        .i_vsync  (i_vsync),
        .i_de     (i_de),
        .i_r      (i_r),
        .i_g      (i_g),
        .i_b      (i_b),
        .i_x      (i_x),
        .i_y      (i_y),
        .i_thresh (thresh),
        .o_window (window),
        .o_hsync  (lb_hsync),
        .o_vsync  (lb_vsync),
        .o_de     (lb_de),
        .o_x      (lb_x),
        .o_y      (lb_y)
    );

    bin_morph #(
        .H_ACT  (H_ACT),
        .V_ACT  (V_ACT),
        .COLUMN (COLUMN)
    ) u_morph (
        .clk      (clk),
        .rstn     (rstn),
        .i_window (window),
        .i_hsync  (lb_hsync),
        .i_vsync  (lb_vsync),
        .i_de     (lb_de),
        .i_x      (lb_x),
        .i_y      (lb_y),
        .i_mode   (mode),
        .o_r      (o_r),
        .o_g      (o_g),
        .o_b      (o_b),
        .o_hsync  (o_hsync),
        .o_vsync  (o_vsync),
        .o_de     (o_de),
        .o_x      (o_x),
        .o_y      (o_y)
    );

endmodule : bin_filter_top

// ==== tb_bin_filter_asserts.sv ====
module tb_bin_filter_asserts
    import video_pkg::*, csr_pkg::*;
#(
    parameter  int H_ACT  = 16,
    parameter  int V_ACT  = 8,
    parameter  int COLUMN = 3,
    localparam int XW     = $clog2(H_ACT),
    localparam int YW     = $clog2(V_ACT)
) (
    input logic                clk,
    input logic                rstn,
    input logic                i_wb_cyc,
    input logic                i_wb_stb,
    input logic                i_wb_we,
    input logic [wb_adr_w-1:0] i_wb_adr,
    input logic [wb_dat_w-1:0] i_wb_dat,
    input logic [3:0]          i_wb_sel,
    input logic                i_hsync,
    input logic                i_vsync,
    input logic                i_de,
    input logic [pix_w-1:0]    i_r,
    input logic [pix_w-1:0]    i_g,
    input logic [pix_w-1:0]    i_b,
    input logic [XW-1:0]       i_x,
    input logic [YW-1:0]       i_y,
    input logic [wb_dat_w-1:0] o_wb_dat,
    input logic                o_wb_ack,
    input logic [pix_w-1:0]    o_r,
    input logic [pix_w-1:0]    o_g,
    input logic [pix_w-1:0]    o_b,
    input logic                o_hsync,
    input logic                o_vsync,
    input logic                o_de,
    input logic [XW-1:0]       o_x,
    input logic [YW-1:0]       o_y
);

    timeunit 1ns;
    timeprecision 100ps;

    int                     err_cnt = 0;
    logic [1:0]             wr_ctrl;
    logic [thresh_w-1:0]    wr_thresh;
    mode_t                  act_mode;
    logic [thresh_w-1:0]    act_thresh;
    logic [frame_cnt_w-1:0] frames;
    logic                   vsync_prev;
    logic                   bits [V_ACT][H_ACT]; // binary image of the current frame
    logic [1:0]             de_d;
    logic [1:0]             hs_d;
    logic [1:0]             vs_d;
    logic [XW-1:0]          x_d [2];
    logic [YW-1:0]          y_d [2];
    logic                   exp_white;
    logic [pix_w-1:0]       exp_pix;
    logic [YW-1:0]          exp_y;
    logic [wb_dat_w-1:0]    exp_rd;

    // register model, shadows follow vsync
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ctrl    <= '0;
            wr_thresh  <= '0;
            act_mode   <= MODE_PASS;
            act_thresh <= '0;
            frames     <= '0;
            vsync_prev <= 1'b0;
        end else begin
            if (o_wb_ack && i_wb_we && i_wb_sel[0]) begin
                if (i_wb_adr == adr_ctrl) begin
                    wr_ctrl <= i_wb_dat[1:0];
                end
                if (i_wb_adr == adr_thresh) begin
                    wr_thresh <= i_wb_dat[thresh_w-1:0];
                end
            end
            if (i_vsync) begin
                act_mode   <= mode_t'(wr_ctrl);
                act_thresh <= wr_thresh;
            end
            vsync_prev <= i_vsync;
            if (i_vsync && !vsync_prev) begin
                frames <= frames + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (i_de) begin
            bits[i_y][i_x] <= (i_r > act_thresh) || (i_g > act_thresh) || (i_b > act_thresh);
        end
        de_d <= {de_d[0], i_de};
        hs_d <= {hs_d[0], i_hsync};
        vs_d <= {vs_d[0], i_vsync};
        x_d[0] <= i_x;
        x_d[1] <= x_d[0];
        y_d[0] <= i_y;
        y_d[1] <= y_d[0];
    end

    // window of rows exp_y..exp_y+2, columns x-2..x
    always_comb begin
        int   xc;
        int   yr;
        logic all_set;
        logic any_set;
        all_set = 1'b1;
        any_set = 1'b0;
        for (int dy = 0; dy < COLUMN; dy++) begin
            for (int dx = 0; dx < COLUMN; dx++) begin
                xc = int'(x_d[1]) - dx;
                yr = int'(exp_y) + dy;
                if (xc < 0 || yr >= V_ACT) begin
                    all_set = 1'b0; // outside the image
                end else begin
                    all_set = all_set & bits[yr][xc];
                    any_set = any_set | bits[yr][xc];
                end
            end
        end
        case (act_mode)
            MODE_ERODE:  exp_white = all_set;
            MODE_DILATE: exp_white = any_set;
            default:     exp_white = bits[exp_y][x_d[1]];
        endcase
    end

    // input row minus two, never below row 0
    assign exp_y   = (int'(y_d[1]) > COLUMN - 2) ? YW'(int'(y_d[1]) - COLUMN + 1) : '0;
    assign exp_pix = (de_d[1] && y_d[1] >= YW'(COLUMN - 1) && exp_white) ? bin_white : bin_black;

    always_comb begin
        case (i_wb_adr)
            adr_ctrl:   exp_rd = wb_dat_w'(wr_ctrl);
            adr_thresh: exp_rd = wb_dat_w'(wr_thresh);
            adr_frames: exp_rd = wb_dat_w'(frames);
            default:    exp_rd = '0;
        endcase
    end

    a_reset: assert property (@(posedge clk)
        !rstn |=> !o_wb_ack && !o_de && !o_hsync && !o_vsync)
        else begin
            err_cnt++;
            $error("outputs not low after a reset cycle");
        end

    a_ack_rise: assert property (@(posedge clk) disable iff (!rstn)
        $rose(i_wb_cyc && i_wb_stb) |=> o_wb_ack)
        else begin
            err_cnt++;
            $error("Fail %0t o_wb_ack got 0 exp 1", $time);
        end

    a_ack_len: assert property (@(posedge clk) disable iff (!rstn) o_wb_ack |=> !o_wb_ack)
        else begin
            err_cnt++;
            $error("Fail %0t o_wb_ack got 1 exp 0", $time);
        end

    // ack only follows a fresh request, never a held stb
    a_ack_req: assert property (@(posedge clk) disable iff (!rstn)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb) && !$past(i_wb_cyc && i_wb_stb, 2))
        else begin
            err_cnt++;
            $error("ack without a new preceding request");
        end

    a_rd_data: assert property (@(posedge clk) disable iff (!rstn)
        o_wb_ack && !i_wb_we |-> o_wb_dat == exp_rd)
        else begin
            err_cnt++;
            $error("Fail %0t o_wb_dat got %h exp %h", $time, $sampled(o_wb_dat),
                   $sampled(exp_rd));
        end

    a_syncs: assert property (@(posedge clk) disable iff (!rstn)
        o_de == de_d[1] && o_hsync == hs_d[1] && o_vsync == vs_d[1])
        else begin
            err_cnt++;
            $error("Fail %0t o_de/o_hsync/o_vsync got %b%b%b exp %b%b%b", $time,
                   $sampled(o_de), $sampled(o_hsync), $sampled(o_vsync),
                   $sampled(de_d[1]), $sampled(hs_d[1]), $sampled(vs_d[1]));
        end

    a_x: assert property (@(posedge clk) disable iff (!rstn) o_x == x_d[1])
        else begin
            err_cnt++;
            $error("Fail %0t o_x got %0d exp %0d", $time, $sampled(o_x), $sampled(x_d[1]));
        end

    a_y: assert property (@(posedge clk) disable iff (!rstn) o_y == exp_y)
        else begin
            err_cnt++;
            $error("Fail %0t o_y got %0d exp %0d", $time, $sampled(o_y), $sampled(exp_y));
        end

    a_pixel: assert property (@(posedge clk) disable iff (!rstn) o_r == exp_pix)
        else begin
            err_cnt++;
            $error("Fail %0t o_r got %h exp %h", $time, $sampled(o_r), $sampled(exp_pix));
        end

    a_channels: assert property (@(posedge clk) disable iff (!rstn) o_g == o_r && o_b == o_r)
        else begin
            err_cnt++;
            $error("Fail %0t o_g/o_b got %h/%h exp %h", $time, $sampled(o_g), $sampled(o_b),
                   $sampled(o_r));
        end

endmodule : tb_bin_filter_asserts

bind bin_filter_top tb_bin_filter_asserts #(
    .H_ACT  (H_ACT),
    .V_ACT  (V_ACT),
    .COLUMN (COLUMN)
) u_chk (.*);

// ==== tb_bin_filter.sv ====
module tb_bin_filter
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACT  = 16;
    localparam int V_ACT  = 8;
    localparam int COLUMN = 3;
    localparam int XW     = $clog2(H_ACT);
    localparam int YW     = $clog2(V_ACT);

    logic                clk      = 1'b0;
    logic                rstn     = 1'b0;
    logic                i_wb_cyc = 1'b0;
    logic                i_wb_stb = 1'b0;
    logic                i_wb_we  = 1'b0;
    logic [wb_adr_w-1:0] i_wb_adr = '0;
    logic [wb_dat_w-1:0] i_wb_dat = '0;
    logic [3:0]          i_wb_sel = '0;
    logic                i_hsync  = 1'b0;
    logic                i_vsync  = 1'b0;
    logic                i_de     = 1'b0;
    logic [7:0]          i_r      = '0;
    logic [7:0]          i_g      = '0;
    logic [7:0]          i_b      = '0;
    logic [XW-1:0]       i_x      = '0;
    logic [YW-1:0]       i_y      = '0;
    logic [wb_dat_w-1:0] o_wb_dat;
    logic                o_wb_ack;
    logic [7:0]          o_r;
    logic [7:0]          o_g;
    logic [7:0]          o_b;
    logic                o_hsync;
    logic                o_vsync;
    logic                o_de;
    logic [XW-1:0]       o_x;
    logic [YW-1:0]       o_y;
    logic [31:0]         rng = 32'hee15;

    bin_filter_top #(
        .H_ACT  (H_ACT),
        .V_ACT  (V_ACT),
        .COLUMN (COLUMN)
    ) i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    always @(negedge clk) begin
        if (i_dut.u_chk.err_cnt != 0) begin
            abort_run("a bound assertion failed");
        end
    end

    task automatic wb_access(input logic we, input logic [wb_adr_w-1:0] adr,
                             input logic [wb_dat_w-1:0] dat, input int hold = 0);
        int n;
        @(negedge clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        i_wb_sel = 4'h1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!o_wb_ack && n < 20);
        if (!o_wb_ack) begin
            abort_run("no Wishbone ack within 20 cycles");
        end
        repeat (hold) @(negedge clk); // stb kept high past the ack
        i_wb_cyc = 1'b0; // we, adr and dat stay put
        i_wb_stb = 1'b0;
    endtask

    task automatic wait_row(input int row);
        int n;
        n = 0;
        while (i_y != YW'(row) && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (i_y != YW'(row)) begin
            abort_run("timed out waiting for an input row");
        end
    endtask

    task automatic send_frame();
        repeat (2) @(negedge clk);
        i_vsync = 1'b1;
        i_x     = '0;
        i_y     = '0;
        repeat (2) @(negedge clk);
        i_vsync = 1'b0;
        repeat (2) @(negedge clk);
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                rng = xorshift(rng);
                @(negedge clk);
                i_de = 1'b1;
                i_x  = XW'(x);
                i_y  = YW'(y);
                i_r  = rng[7:0];
                i_g  = rng[15:8];
                i_b  = rng[23:16];
            end
            @(negedge clk);
            i_de = 1'b0; // 4 blanking cycles, hsync in the middle two
            @(negedge clk);
            i_hsync = 1'b1;
            @(negedge clk);
            @(negedge clk);
            i_hsync = 1'b0;
        end
    endtask

    initial begin
        logic [7:0] thr;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        wb_access(1'b1, adr_thresh, '0, 2); // non-black test first
        wb_access(1'b1, adr_ctrl, '0);
        wb_access(1'b0, adr_ctrl, '0, 2);
        wb_access(1'b0, adr_thresh, '0);
        wb_access(1'b0, 4'd7, '0);
        // three frames each of pass, erode, dilate
        for (int f = 0; f < 9; f++) begin
            rng = xorshift(rng);
            thr = rng[7:0];
            fork
                send_frame();
                begin
                    wait_row(3);
                    wb_access(1'b1, adr_thresh, wb_dat_w'(thr));
                    if (f % 3 == 2) begin
                        wb_access(1'b1, adr_ctrl, wb_dat_w'(f / 3 + 1)); // next mode
                    end
                    wb_access(1'b0, adr_thresh, '0);
                    wb_access(1'b0, adr_ctrl, '0);
                    wb_access(1'b0, adr_frames, '0);
                end
            join
        end
        repeat (4) @(negedge clk);
        wb_access(1'b0, adr_frames, '0);
        repeat (2) @(negedge clk);
        if (i_dut.u_chk.err_cnt != 0) begin
            abort_run("assertion errors at end of run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule : tb_bin_filter

// ==== all.f ====
video_pkg.sv
csr_pkg.sv
bin_csr.sv
bin_line_buffers.sv
bin_morph.sv
bin_filter_top.sv
tb_bin_filter_asserts.sv
tb_bin_filter.sv
